//--- rtl/lcd_pkg.sv
// LCD controller definitions
`default_nettype none

package lcd_pkg;

  // widths with a meaning on the bus or the pins
  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_id_t;
  typedef logic [1:0]  axi_resp_t;
  typedef logic [15:0] lcd_word_t;
  typedef logic [3:0]  bus_phase_t;

  // register map
  localparam axi_addr_t lcd_cmd_addr  = 32'h1fd0_c000;
  localparam axi_addr_t lcd_data_addr = lcd_cmd_addr + 32'd4;
  localparam axi_data_t bad_read_word = 32'heeee_eeee;

  // 8080 write cycle timing, in pclk cycles
  localparam int lcd_setup_cycles  = 1;
  localparam int lcd_wr_low_cycles = 2;
  localparam int lcd_hold_cycles   = 1;

  // command queue sizing
  localparam int queue_depth = 4;
  localparam int queue_ptr_w = $clog2(queue_depth);
  localparam int queue_cnt_w = $clog2(queue_depth + 1);

  // standard AXI response codes
  localparam axi_resp_t resp_okay   = 2'b00;
  localparam axi_resp_t resp_slverr = 2'b10;
  localparam axi_resp_t resp_decerr = 2'b11;

  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_ar_t;

  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_aw_t;

  typedef struct packed {
    axi_data_t  data;
    logic [3:0] strb;
    logic       last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  // one queued LCD word, rs high means display data
  typedef struct packed {
    logic      rs;
    lcd_word_t data;
  } lcd_cmd_t;

  typedef enum logic {
    rd_addr,
    rd_data
  } rd_state_t;

  typedef enum logic [1:0] {
    wr_idle,
    wr_addr,
    wr_data,
    wr_resp
  } wr_state_t;

  typedef enum logic [1:0] {
    bus_idle,
    bus_setup,
    bus_strobe,
    bus_hold
  } bus_state_t;

endpackage

`default_nettype wire

//--- rtl/lcd_cmd_queue.sv
// LCD command queue
`timescale 1ns/1ps
`default_nettype none

module lcd_cmd_queue (
  input  wire                    pclk,
  input  wire                    rst_n,
  input  wire                    cmd_push,
  input  wire lcd_pkg::lcd_cmd_t cmd,
  input  wire                    cmd_pop,
  output logic                   cmd_room,
  output logic                   cmd_avail,
  output lcd_pkg::lcd_cmd_t      head
);
  import lcd_pkg::*;

  lcd_cmd_t               mem [queue_depth];
  logic [queue_ptr_w-1:0] wr_ptr;
  logic [queue_ptr_w-1:0] rd_ptr;
  logic [queue_cnt_w-1:0] count;
  logic                   push_ok;
  logic                   pop_ok;

  assign cmd_room  = (count != queue_cnt_w'(queue_depth));
  assign cmd_avail = (count != '0);
  assign head      = mem[rd_ptr];

  assign push_ok = cmd_push && cmd_room;
  assign pop_ok  = cmd_pop && cmd_avail;

  // storage
  always_ff @(posedge pclk) begin
    if (push_ok) begin
      mem[wr_ptr] <= cmd;
    end
  end

  // pointers wrap at the last entry
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_ok) begin
        if (wr_ptr == queue_ptr_w'(queue_depth - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop_ok) begin
        if (rd_ptr == queue_ptr_w'(queue_depth - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // occupancy, push and pop together leave it unchanged
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/lcd_bus_engine.sv
// 8080 parallel bus write engine
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_engine (
  input  wire                     pclk,
  input  wire                     rst_n,
  input  wire                     cmd_avail,
  input  wire lcd_pkg::lcd_cmd_t  head,
  output logic                    cmd_pop,
  output logic                    lcd_cs_n,
  output logic                    lcd_rs,
  output logic                    lcd_wr_n,
  output lcd_pkg::lcd_word_t      lcd_dout,
  input  wire lcd_pkg::lcd_word_t lcd_din,
  output lcd_pkg::axi_data_t      lcd_in_word
);
  import lcd_pkg::*;

  bus_state_t state;
  bus_state_t state_next;
  bus_phase_t phase;
  bus_phase_t phase_limit;
  logic       phase_done;
  lcd_word_t  din_meta;
  lcd_word_t  din_sync;

  // take the head word whenever the bus is free
  assign cmd_pop = (state == bus_idle) && cmd_avail;

  // last phase index of the current state
  always_comb begin
    case (state)
      bus_setup:  phase_limit = bus_phase_t'(lcd_setup_cycles - 1);
      bus_strobe: phase_limit = bus_phase_t'(lcd_wr_low_cycles - 1);
      bus_hold:   phase_limit = bus_phase_t'(lcd_hold_cycles - 1);
      default:    phase_limit = '0;
    endcase
  end

  assign phase_done = (phase == phase_limit);

  always_comb begin
    state_next = state;
    case (state)
      bus_idle: begin
        if (cmd_avail) begin
          state_next = bus_setup;
        end
      end
      bus_setup: begin
        if (phase_done) begin
          state_next = bus_strobe;
        end
      end
      bus_strobe: begin
        if (phase_done) begin
          state_next = bus_hold;
        end
      end
      bus_hold: begin
        if (phase_done) begin
          state_next = bus_idle;
        end
      end
      default: state_next = bus_idle;
    endcase
  end

  // strobes come from the next state so the pins are flop outputs
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      state    <= bus_idle;
      phase    <= '0;
      lcd_cs_n <= 1'b1;
      lcd_wr_n <= 1'b1;
    end else begin
      state    <= state_next;
      lcd_cs_n <= (state_next == bus_idle);
      lcd_wr_n <= (state_next != bus_strobe);
      if (state_next != state) begin
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  // rs and data stay put for the whole cycle
  always_ff @(posedge pclk) begin
    if (cmd_pop) begin
      lcd_rs   <= head.rs;
      lcd_dout <= head.data;
    end
  end

  // two-flop synchronizer on the input pins
  always_ff @(posedge pclk) begin
    din_meta <= lcd_din;
    din_sync <= din_meta;
  end

  assign lcd_in_word = axi_data_t'(din_sync);

endmodule

`default_nettype wire

//--- rtl/lcd_axi_bridge.sv
// AXI slave bridge for the LCD
`timescale 1ns/1ps
`default_nettype none

module lcd_axi_bridge (
  input  wire                 pclk,
  input  wire                 rst_n,
  input  wire lcd_pkg::axi_ar_t  ar,
  input  wire                 ar_valid,
  output logic                ar_ready,
  output lcd_pkg::axi_r_t     r,
  output logic                r_valid,
  input  wire                 r_ready,
  input  wire lcd_pkg::axi_aw_t  aw,
  input  wire                 aw_valid,
  output logic                aw_ready,
  input  wire lcd_pkg::axi_w_t   w,
  input  wire                 w_valid,
  output logic                w_ready,
  output lcd_pkg::axi_b_t     b,
  output logic                b_valid,
  input  wire                 b_ready,
  input  wire                 cmd_room,
  output logic                cmd_push,
  output lcd_pkg::lcd_cmd_t   cmd,
  input  wire lcd_pkg::axi_data_t lcd_in_word,
  input  wire lcd_pkg::axi_data_t touch_status
);
  import lcd_pkg::*;

  rd_state_t rd_state;
  wr_state_t wr_state;

  logic      ar_fire;
  logic      aw_fire;
  logic      w_fire;
  axi_data_t rd_sel_data;
  axi_resp_t rd_sel_resp;

  axi_addr_t aw_addr_q;
  logic      wr_full;
  logic      wr_mapped;
  logic      wr_forward;
  axi_resp_t wr_resp_code;

  // handshakes follow directly from the state
  assign ar_ready = (rd_state == rd_addr);
  assign r_valid  = (rd_state == rd_data);
  assign aw_ready = (wr_state == wr_addr);
  assign w_ready  = (wr_state == wr_data);
  assign b_valid  = (wr_state == wr_resp);

  assign ar_fire = ar_valid && ar_ready;
  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;

  // read data select from the address map
  always_comb begin
    rd_sel_resp = resp_okay;
    case (ar.addr)
      lcd_cmd_addr:  rd_sel_data = lcd_in_word;
      lcd_data_addr: rd_sel_data = touch_status;
      default: begin
        rd_sel_data = bad_read_word;
        rd_sel_resp = resp_decerr;
      end
    endcase
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      rd_state <= rd_addr;
    end else begin
      case (rd_state)
        rd_addr: begin
          if (ar_fire) begin
            rd_state <= rd_data;
          end
        end
        rd_data: begin
          if (r_ready) begin
            rd_state <= rd_addr;
          end
        end
        default: rd_state <= rd_addr;
      endcase
    end
  end

  // response is captured once and held until accepted
  always_ff @(posedge pclk) begin
    if (ar_fire) begin
      r.id   <= ar.id;
      r.data <= rd_sel_data;
      r.resp <= rd_sel_resp;
      r.last <= 1'b1;
    end
  end

  // forward only full-word writes to a mapped register
  assign wr_full    = &w.strb;
  assign wr_mapped  = (aw_addr_q == lcd_cmd_addr) || (aw_addr_q == lcd_data_addr);
  assign wr_forward = wr_full && wr_mapped;

  always_comb begin
    if (!wr_full) begin
      wr_resp_code = resp_slverr;
    end else if (!wr_mapped) begin
      wr_resp_code = resp_decerr;
    end else begin
      wr_resp_code = resp_okay;
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      wr_state <= wr_idle;
      cmd_push <= 1'b0;
    end else begin
      cmd_push <= w_fire && wr_forward;
      case (wr_state)
        // wait for queue room before taking an address
        wr_idle: begin
          if (cmd_room) begin
            wr_state <= wr_addr;
          end
        end
        wr_addr: begin
          if (aw_fire) begin
            wr_state <= wr_data;
          end
        end
        wr_data: begin
          if (w_fire) begin
            wr_state <= wr_resp;
          end
        end
        wr_resp: begin
          if (b_ready) begin
            wr_state <= wr_idle;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge pclk) begin
    if (aw_fire) begin
      aw_addr_q <= aw.addr;
      b.id      <= aw.id;
    end
    if (w_fire) begin
      b.resp   <= wr_resp_code;
      cmd.rs   <= (aw_addr_q == lcd_data_addr);
      cmd.data <= w.data[15:0];
    end
  end

endmodule

`default_nettype wire

//--- rtl/lcd_top.sv
// LCD controller top level
`timescale 1ns/1ps
`default_nettype none

module lcd_top (
  input  wire                     pclk,
  input  wire                     rst_n,
  input  wire lcd_pkg::axi_ar_t   ar,
  input  wire                     ar_valid,
  output logic                    ar_ready,
  output lcd_pkg::axi_r_t         r,
  output logic                    r_valid,
  input  wire                     r_ready,
  input  wire lcd_pkg::axi_aw_t   aw,
  input  wire                     aw_valid,
  output logic                    aw_ready,
  input  wire lcd_pkg::axi_w_t    w,
  input  wire                     w_valid,
  output logic                    w_ready,
  output lcd_pkg::axi_b_t         b,
  output logic                    b_valid,
  input  wire                     b_ready,
  output logic                    lcd_cs_n,
  output logic                    lcd_rs,
  output logic                    lcd_wr_n,
  output lcd_pkg::lcd_word_t      lcd_dout,
  input  wire lcd_pkg::lcd_word_t lcd_din,
  input  wire lcd_pkg::axi_data_t touch_status
);
  import lcd_pkg::*;

  // bridge to queue
  logic      cmd_push;
  lcd_cmd_t  cmd;
  logic      cmd_room;

  // queue to engine
  logic      cmd_avail;
  logic      cmd_pop;
  lcd_cmd_t  head;

  // synchronized pin word back to the register map
  axi_data_t lcd_in_word;

  lcd_axi_bridge u_bridge (
    .pclk         (pclk),
    .rst_n        (rst_n),
    .ar           (ar),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .r            (r),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .aw           (aw),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .w            (w),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .b            (b),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .cmd_room     (cmd_room),
    .cmd_push     (cmd_push),
    .cmd          (cmd),
    .lcd_in_word  (lcd_in_word),
    .touch_status (touch_status)
  );

  lcd_cmd_queue u_queue (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .cmd_push  (cmd_push),
    .cmd       (cmd),
    .cmd_pop   (cmd_pop),
    .cmd_room  (cmd_room),
    .cmd_avail (cmd_avail),
    .head      (head)
  );

  lcd_bus_engine u_engine (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .cmd_avail   (cmd_avail),
    .head        (head),
    .cmd_pop     (cmd_pop),
    .lcd_cs_n    (lcd_cs_n),
    .lcd_rs      (lcd_rs),
    .lcd_wr_n    (lcd_wr_n),
    .lcd_dout    (lcd_dout),
    .lcd_din     (lcd_din),
    .lcd_in_word (lcd_in_word)
  );

endmodule

`default_nettype wire

//--- bench/lcd_checker.sv
// LCD controller response checker
`timescale 1ns/1ps
`default_nettype none

module lcd_checker (
  input wire                     pclk,
  input wire                     rst_n,
  input wire lcd_pkg::axi_r_t    r,
  input wire                     r_valid,
  input wire                     r_ready,
  input wire lcd_pkg::axi_b_t    b,
  input wire                     b_valid,
  input wire                     b_ready,
  input wire                     lcd_cs_n,
  input wire                     lcd_rs,
  input wire                     lcd_wr_n,
  input wire lcd_pkg::lcd_word_t lcd_dout
);
  import lcd_pkg::*;

  lcd_cmd_t lcd_exp[$];
  axi_r_t   r_exp[$];
  axi_b_t   b_exp[$];
  int       errors = 0;

  // held responses from the previous cycle
  logic     r_held = 1'b0;
  logic     b_held = 1'b0;
  axi_r_t   r_last;
  axi_b_t   b_last;

  // pin cycle widths of the current LCD write
  int       cs_low_cycles = 0;
  int       wr_low_cycles = 0;

  task automatic expect_lcd(input lcd_cmd_t c);
    lcd_exp.push_back(c);
  endtask

  task automatic expect_r(input axi_r_t v);
    r_exp.push_back(v);
  endtask

  task automatic expect_b(input axi_b_t v);
    b_exp.push_back(v);
  endtask

  function automatic int pending();
    return lcd_exp.size() + r_exp.size() + b_exp.size();
  endfunction

  // one word per strobe while rs and data are stable
  always @(negedge lcd_wr_n) begin
    lcd_cmd_t got;
    lcd_cmd_t exp;
    got = '{rs: lcd_rs, data: lcd_dout};
    if (rst_n) begin
      if (lcd_exp.size() == 0) begin
        errors++;
        $display("unexpected LCD write cycle with word %h", got);
      end else begin
        exp = lcd_exp.pop_front();
        if (got !== exp) begin
          errors++;
          $display("FAILED lcd_word expected %h actual %h", exp, got);
        end
      end
    end
  end

  // chip select and strobe widths of each write cycle
  always @(posedge pclk) begin
    if (!rst_n) begin
      cs_low_cycles = 0;
      wr_low_cycles = 0;
    end else if (!lcd_cs_n) begin
      cs_low_cycles++;
      if (!lcd_wr_n) begin
        wr_low_cycles++;
      end
    end else if (cs_low_cycles != 0) begin
      if (cs_low_cycles != lcd_setup_cycles + lcd_wr_low_cycles + lcd_hold_cycles) begin
        errors++;
        $display("FAILED cs_cycles expected %0d actual %0d",
                 lcd_setup_cycles + lcd_wr_low_cycles + lcd_hold_cycles, cs_low_cycles);
      end
      if (wr_low_cycles != lcd_wr_low_cycles) begin
        errors++;
        $display("FAILED wr_cycles expected %0d actual %0d",
                 lcd_wr_low_cycles, wr_low_cycles);
      end
      cs_low_cycles = 0;
      wr_low_cycles = 0;
    end
  end

  always @(posedge pclk) begin
    axi_r_t er;
    axi_b_t eb;
    if (!rst_n) begin
      r_held = 1'b0;
      b_held = 1'b0;
    end else begin
      if (r_valid) begin
        if (r_held && (r !== r_last)) begin
          errors++;
          $display("FAILED r_hold expected %h actual %h", r_last, r);
        end
        if (r_ready) begin
          if (r_exp.size() == 0) begin
            errors++;
            $display("read response arrived with none expected");
          end else begin
            er = r_exp.pop_front();
            if (r !== er) begin
              errors++;
              $display("FAILED r_resp expected %h actual %h", er, r);
            end
          end
        end
      end
      r_held = r_valid && !r_ready;
      r_last = r;
      if (b_valid) begin
        if (b_held && (b !== b_last)) begin
          errors++;
          $display("FAILED b_hold expected %h actual %h", b_last, b);
        end
        if (b_ready) begin
          if (b_exp.size() == 0) begin
            errors++;
            $display("write response arrived with none expected");
          end else begin
            eb = b_exp.pop_front();
            if (b !== eb) begin
              errors++;
              $display("FAILED b_resp expected %h actual %h", eb, b);
            end
          end
        end
      end
      b_held = b_valid && !b_ready;
      b_last = b;
    end
  end

endmodule

`default_nettype wire

//--- bench/lcd_asserts.sv
// LCD controller protocol assertions
`timescale 1ns/1ps
`default_nettype none

module lcd_asserts (
  input wire                     pclk,
  input wire                     rst_n,
  input wire                     r_valid,
  input wire                     r_ready,
  input wire                     b_valid,
  input wire                     b_ready,
  input wire                     lcd_cs_n,
  input wire                     lcd_wr_n,
  input wire lcd_pkg::lcd_word_t lcd_dout
);

  r_hold: assert property (@(posedge pclk) disable iff (!rst_n)
    r_valid && !r_ready |=> r_valid) else $error("rvalid dropped before rready");

  b_hold: assert property (@(posedge pclk) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid) else $error("bvalid dropped before bready");

  wr_in_cs: assert property (@(posedge pclk) disable iff (!rst_n)
    !lcd_wr_n |-> !lcd_cs_n) else $error("write strobe outside chip select");

  dout_stable: assert property (@(posedge pclk) disable iff (!rst_n)
    !lcd_wr_n |=> lcd_wr_n || $stable(lcd_dout)) else $error("data moved under strobe");

endmodule

bind lcd_top lcd_asserts u_asserts (
  .pclk     (pclk),
  .rst_n    (rst_n),
  .r_valid  (r_valid),
  .r_ready  (r_ready),
  .b_valid  (b_valid),
  .b_ready  (b_ready),
  .lcd_cs_n (lcd_cs_n),
  .lcd_wr_n (lcd_wr_n),
  .lcd_dout (lcd_dout)
);

`default_nettype wire

//--- bench/tb_lcd_top.sv
// LCD controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_top;
  import lcd_pkg::*;

  localparam int wait_limit  = 200;
  localparam int drain_limit = 2000;

  logic      pclk;
  logic      rst_n;
  axi_ar_t   ar;
  logic      ar_valid;
  logic      ar_ready;
  axi_r_t    r;
  logic      r_valid;
  logic      r_ready;
  axi_aw_t   aw;
  logic      aw_valid;
  logic      aw_ready;
  axi_w_t    w;
  logic      w_valid;
  logic      w_ready;
  axi_b_t    b;
  logic      b_valid;
  logic      b_ready;
  logic      lcd_cs_n;
  logic      lcd_rs;
  logic      lcd_wr_n;
  lcd_word_t lcd_dout;
  lcd_word_t lcd_din;
  axi_data_t touch_status;

  integer    seed;
  int        bench_errors;
  logic      fast_ready;

  lcd_top uut (
    .pclk (pclk), .rst_n (rst_n),
    .ar (ar), .ar_valid (ar_valid), .ar_ready (ar_ready),
    .r (r), .r_valid (r_valid), .r_ready (r_ready),
    .aw (aw), .aw_valid (aw_valid), .aw_ready (aw_ready),
    .w (w), .w_valid (w_valid), .w_ready (w_ready),
    .b (b), .b_valid (b_valid), .b_ready (b_ready),
    .lcd_cs_n (lcd_cs_n), .lcd_rs (lcd_rs), .lcd_wr_n (lcd_wr_n),
    .lcd_dout (lcd_dout), .lcd_din (lcd_din), .touch_status (touch_status)
  );

  lcd_checker chk (
    .pclk (pclk), .rst_n (rst_n),
    .r (r), .r_valid (r_valid), .r_ready (r_ready),
    .b (b), .b_valid (b_valid), .b_ready (b_ready),
    .lcd_cs_n (lcd_cs_n), .lcd_rs (lcd_rs), .lcd_wr_n (lcd_wr_n), .lcd_dout (lcd_dout)
  );

  initial pclk = 1'b0;
  always #5 pclk = ~pclk;

  // random response back-pressure unless a burst wants it open
  always @(posedge pclk) begin
    #1;
    if (fast_ready) begin
      r_ready = 1'b1;
      b_ready = 1'b1;
    end else begin
      r_ready = ($random(seed) & 3) != 0;
      b_ready = ($random(seed) & 3) == 0;
    end
  end

  task automatic finish_run();
    $display("errors: %0d checker, %0d bench", chk.errors, bench_errors);
    if (chk.errors + bench_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    bench_errors++;
    $display("timeout while waiting for %s", what);
    finish_run();
  endtask

  task automatic write_word(input axi_addr_t addr, input axi_data_t data,
                            input logic [3:0] strb, input axi_id_t id);
    int     cycles;
    axi_b_t eb;
    logic   mapped;
    mapped = (addr == lcd_cmd_addr) || (addr == lcd_data_addr);
    eb.id  = id;
    if (strb != 4'hf) begin
      eb.resp = resp_slverr;
    end else if (!mapped) begin
      eb.resp = resp_decerr;
    end else begin
      eb.resp = resp_okay;
      chk.expect_lcd('{rs: (addr == lcd_data_addr), data: data[15:0]});
    end
    chk.expect_b(eb);
    aw       = '{id: id, addr: addr, len: 8'd0, size: 3'd2, burst: 2'b01};
    aw_valid = 1'b1;
    cycles   = 0;
    do begin
      @(posedge pclk);
      cycles++;
    end while (!aw_ready && cycles < wait_limit);
    if (!aw_ready) timed_out("awready");
    #1;
    aw_valid = 1'b0;
    w        = '{data: data, strb: strb, last: 1'b1};
    w_valid  = 1'b1;
    cycles   = 0;
    do begin
      @(posedge pclk);
      cycles++;
    end while (!w_ready && cycles < wait_limit);
    if (!w_ready) timed_out("wready");
    #1;
    w_valid = 1'b0;
  endtask

  task automatic read_word(input axi_addr_t addr, input axi_id_t id);
    int     cycles;
    axi_r_t er;
    er.id   = id;
    er.last = 1'b1;
    er.resp = resp_okay;
    if (addr == lcd_cmd_addr) begin
      er.data = {16'h0, lcd_din};
    end else if (addr == lcd_data_addr) begin
      er.data = touch_status;
    end else begin
      er.data = bad_read_word;
      er.resp = resp_decerr;
    end
    chk.expect_r(er);
    ar       = '{id: id, addr: addr, len: 8'd0, size: 3'd2, burst: 2'b01};
    ar_valid = 1'b1;
    cycles   = 0;
    do begin
      @(posedge pclk);
      cycles++;
    end while (!ar_ready && cycles < wait_limit);
    if (!ar_ready) timed_out("arready");
    #1;
    ar_valid = 1'b0;
    cycles   = 0;
    do begin
      @(posedge pclk);
      cycles++;
    end while (!(r_valid && r_ready) && cycles < wait_limit);
    if (!(r_valid && r_ready)) timed_out("read response");
    #1;
  endtask

  // new pin and touch values held long enough to pass the synchronizer
  task automatic set_inputs();
    lcd_din      = lcd_word_t'($random(seed));
    touch_status = $random(seed);
    repeat (3) @(posedge pclk);
    #1;
  endtask

  function automatic axi_addr_t pick_addr();
    case ($random(seed) & 3)
      0, 1: return lcd_cmd_addr;
      2: return lcd_data_addr;
      default: return lcd_cmd_addr + 32'h100 + 32'(($random(seed) & 15) * 4);
    endcase
  endfunction

  initial begin
    int cycles;
    seed = 32'hf4adfa5b;
    bench_errors = 0;
    fast_ready = 1'b0;
    rst_n = 1'b0;
    ar = '0;
    aw = '0;
    w = '0;
    ar_valid = 1'b0;
    aw_valid = 1'b0;
    w_valid = 1'b0;
    r_ready = 1'b0;
    b_ready = 1'b0;
    lcd_din = 16'h1234;
    touch_status = 32'h0;
    repeat (10) @(posedge pclk);
    #1;
    rst_n = 1'b1;

    // quiet bus after reset
    repeat (8) begin
      @(posedge pclk);
      if ({lcd_cs_n, lcd_wr_n, r_valid, b_valid} !== 4'b1100) begin
        bench_errors++;
        $display("FAILED idle_pins expected 1100 actual %b",
                 {lcd_cs_n, lcd_wr_n, r_valid, b_valid});
      end
    end
    #1;

    write_word(lcd_cmd_addr, 32'hdead_002c, 4'hf, 4'h1);
    write_word(lcd_data_addr, 32'hbeef_f800, 4'hf, 4'h2);
    write_word(lcd_cmd_addr, 32'h0000_1111, 4'h3, 4'h3);
    write_word(lcd_cmd_addr + 32'h40, 32'h0000_2222, 4'hf, 4'h4);
    set_inputs();
    read_word(lcd_cmd_addr, 4'h5);
    read_word(lcd_data_addr, 4'h6);
    read_word(lcd_cmd_addr - 32'h4, 4'h7);

    // mixed random traffic with slow responses
    repeat (60) begin
      if ($random(seed) & 1) begin
        write_word(pick_addr(), $random(seed),
                   (($random(seed) & 3) == 0) ? 4'($random(seed)) : 4'hf,
                   axi_id_t'($random(seed)));
      end else begin
        set_inputs();
        read_word(pick_addr(), axi_id_t'($random(seed)));
      end
    end

    // writes faster than the pins drain, long enough to fill the queue
    fast_ready = 1'b1;
    repeat (32) begin
      write_word(($random(seed) & 1) ? lcd_data_addr : lcd_cmd_addr,
                 $random(seed), 4'hf, axi_id_t'($random(seed)));
    end
    fast_ready = 1'b0;

    cycles = 0;
    while (chk.pending() != 0 && cycles < drain_limit) begin
      @(posedge pclk);
      cycles++;
    end
    if (chk.pending() != 0) begin
      timed_out("queued words and responses");
    end else begin
      repeat (5) @(posedge pclk);
      finish_run();
    end
  end

endmodule

`default_nettype wire

//--- project.f
rtl/lcd_pkg.sv
rtl/lcd_cmd_queue.sv
rtl/lcd_bus_engine.sv
rtl/lcd_axi_bridge.sv
rtl/lcd_top.sv
bench/lcd_checker.sv
bench/lcd_asserts.sv
bench/tb_lcd_top.sv

//--- run.sh
#!/bin/sh
# build and run the LCD controller simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lcd_top -f project.f -o sim_lcd

out=$(./obj_dir/sim_lcd)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
